// ==== source/mips_isa_pkg.sv ====
package mips_isa_pkg;

	// one machine word, used for register contents and operands
	typedef logic [31:0] word_t;

	// index into the 32-entry general register file
	typedef logic [4:0] reg_idx_t;

	// the opcode and funct fields are both six bits wide
	typedef logic [5:0] opfield_t;

	// architectural register numbers the operand stage cares about
	localparam reg_idx_t reg_zero = 5'd0;
	localparam reg_idx_t reg_v0 = 5'd2;
	localparam reg_idx_t reg_a0 = 5'd4;
	localparam reg_idx_t reg_sp = 5'd29;
	localparam reg_idx_t reg_ra = 5'd31;

	// opcode values, R-type instructions all share the special opcode
	localparam opfield_t op_special = 6'd0;
	localparam opfield_t op_jal = 6'd3;

	// funct values that only mean something under op_special
	localparam opfield_t fn_syscall = 6'h0c;
	localparam opfield_t fn_mfhi = 6'h10;
	localparam opfield_t fn_mflo = 6'h12;

	// bit ranges of the instruction fields
	// the opcode sits in the top six bits of every format
	localparam int opcode_msb = 31;
	localparam int opcode_lsb = 26;

	// rs and rt are at the same place in R-type and I-type words
	localparam int rs_msb = 25;
	localparam int rs_lsb = 21;
	localparam int rt_msb = 20;
	localparam int rt_lsb = 16;

	// funct occupies the low six bits of an R-type word
	localparam int funct_msb = 5;
	localparam int funct_lsb = 0;

endpackage

// ==== source/regfile_pkg.sv ====
package regfile_pkg;

	import mips_isa_pkg::*;

	// where the two operands of an instruction come from
	typedef enum logic [2:0] {
		sel_regs,
		sel_syscall,
		sel_link,
		sel_hi,
		sel_lo
	} operand_sel_t;

	// decoder result: the two read indices plus the operand source
	typedef struct packed {
		reg_idx_t rs;
		reg_idx_t rt;
		operand_sel_t sel;
	} decode_t;

	// one pending general-register write from an older instruction
	typedef struct packed {
		logic en;
		reg_idx_t dest;
		word_t data;
	} wb_t;

	// one pending hi/lo result from the multiply/divide unit
	typedef struct packed {
		logic en;
		word_t hi;
		word_t lo;
	} hilo_wr_t;

	// everything the requester hands over with req
	typedef struct packed {
		word_t instr;
		word_t pc_plus_4;
		wb_t wb;
		hilo_wr_t hilo;
	} issue_t;

	// the operand pair returned with ack
	typedef struct packed {
		word_t op_a;
		word_t op_b;
	} operands_t;

	// states of the four-phase handshake sequencer
	typedef enum logic [1:0] {
		st_idle,
		st_ack,
		st_release
	} seq_state_t;

endpackage

// ==== source/instr_decode.sv ====
`timescale 1ns/1ps

module instr_decode
	import mips_isa_pkg::*;
	import regfile_pkg::*;
(
	input word_t instr,
	output decode_t dec
);

	// raw instruction fields
	opfield_t opcode;
	opfield_t funct;

	// one flag per special case, evaluated independently
	logic is_special;
	logic is_syscall;
	logic is_jal;
	logic is_mfhi;
	logic is_mflo;

	assign opcode = instr[opcode_msb:opcode_lsb];
	assign funct = instr[funct_msb:funct_lsb];

	// the funct field only matters for R-type words, so every
	// funct match is qualified with the special opcode
	assign is_special = (opcode == op_special);
	assign is_syscall = is_special && (funct == fn_syscall);
	assign is_mfhi = is_special && (funct == fn_mfhi);
	assign is_mflo = is_special && (funct == fn_mflo);
	assign is_jal = (opcode == op_jal);

	always_comb begin
		// read indices are passed through for every format
		// even when the selected source ignores them
		dec.rs = instr[rs_msb:rs_lsb];
		dec.rt = instr[rt_msb:rt_lsb];

		// priority chain, the first match picks the operand source
		// syscall beats jal beats mfhi beats mflo beats plain reads
		if (is_syscall) begin
			dec.sel = sel_syscall;
		end else if (is_jal) begin
			dec.sel = sel_link;
		end else if (is_mfhi) begin
			dec.sel = sel_hi;
		end else if (is_mflo) begin
			dec.sel = sel_lo;
		end else begin
			// every other instruction reads rs and rt as they are
			dec.sel = sel_regs;
		end
	end

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/1ps

module reg_file
	import mips_isa_pkg::*;
	import regfile_pkg::*;
#(
	parameter word_t STACK_TOP = 32'h0000_fffc
) (
	input logic clk,
	input logic arst_n,
	input reg_idx_t rs,
	input reg_idx_t rt,
	input logic commit,
	input wb_t wb,
	input logic link,
	input word_t link_addr,
	output word_t rd_a,
	output word_t rd_b,
	output word_t v0,
	output word_t a0
);

	// the 32 general registers, entry 0 is $zero
	word_t regs [32];

	// a write-back only lands when enabled and not aimed at $zero
	logic wb_write;

	// the link write of a jal, only on a committing edge
	logic link_write;

	assign wb_write = commit && wb.en && (wb.dest != reg_zero);
	assign link_write = commit && link;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			// everything starts at zero except the stack pointer
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
			regs[reg_sp] <= STACK_TOP;
		end else begin
			if (wb_write) begin
				regs[wb.dest] <= wb.data;
			end
			// placed after the write-back so that a jal wins when
			// both target $ra on the same edge
			if (link_write) begin
				regs[reg_ra] <= link_addr;
			end
		end
	end

	// combinational reads see the contents from before this edge,
	// so a request never observes its own pending writes
	// $zero is forced here as well, it must read zero whatever the array holds
	assign rd_a = (rs == reg_zero) ? '0 : regs[rs];
	assign rd_b = (rt == reg_zero) ? '0 : regs[rt];

	// syscall arguments are exported straight from the array
	assign v0 = regs[reg_v0];
	assign a0 = regs[reg_a0];

endmodule

// ==== source/hi_lo_regs.sv ====
`timescale 1ns/1ps

module hi_lo_regs
	import mips_isa_pkg::*;
	import regfile_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic commit,
	input hilo_wr_t wr,
	output word_t hi,
	output word_t lo
);

	// result registers of the multiply/divide unit
	// the arithmetic happens elsewhere, only the values are kept here
	word_t hi_q;
	word_t lo_q;

	// both halves are always written together, as a multiply or
	// divide produces both at once
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			hi_q <= '0;
			lo_q <= '0;
		end else if (commit && wr.en) begin
			hi_q <= wr.hi;
			lo_q <= wr.lo;
		end
	end

	// reads are combinational and show the old pair until the
	// edge that commits the new one
	assign hi = hi_q;
	assign lo = lo_q;

endmodule

// ==== source/operand_fetch.sv ====
`timescale 1ns/1ps

module operand_fetch
	import mips_isa_pkg::*;
	import regfile_pkg::*;
#(
	parameter word_t STACK_TOP = 32'h0000_fffc
) (
	input logic clk,
	input logic arst_n,
	input logic req,
	input issue_t issue,
	output logic ack,
	output operands_t operands,
	output word_t v0,
	output word_t a0
);

	seq_state_t state;
	seq_state_t state_nxt;

	// decoder output for the instruction held on issue
	decode_t dec;

	// commit is high for exactly the one edge that moves idle to ack
	logic commit;
	logic link;

	word_t rd_a;
	word_t rd_b;
	word_t hi;
	word_t lo;

	// operand pair chosen for the current instruction, not yet registered
	operands_t sel_ops;

	instr_decode decode_i (
		.instr (issue.instr),
		.dec   (dec)
	);

	reg_file #(
		.STACK_TOP (STACK_TOP)
	) reg_file_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.rs        (dec.rs),
		.rt        (dec.rt),
		.commit    (commit),
		.wb        (issue.wb),
		.link      (link),
		.link_addr (issue.pc_plus_4),
		.rd_a      (rd_a),
		.rd_b      (rd_b),
		.v0        (v0),
		.a0        (a0)
	);

	hi_lo_regs hi_lo_i (
		.clk    (clk),
		.arst_n (arst_n),
		.commit (commit),
		.wr     (issue.hilo),
		.hi     (hi),
		.lo     (lo)
	);

	// handshake sequencer
	// a request is accepted in idle only, one held in release waits a cycle
	always_comb begin
		state_nxt = state;
		case (state)
			st_idle:    if (req) state_nxt = st_ack;
			// stay here for as long as the requester keeps req high
			st_ack:     if (!req) state_nxt = st_release;
			st_release: state_nxt = st_idle;
			default:    state_nxt = st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
		end else begin
			state <= state_nxt;
		end
	end

	// everything that writes state hangs off this single pulse,
	// so a held req can never commit twice
	assign commit = (state == st_idle) && req;
	assign link = commit && (dec.sel == sel_link);
	assign ack = (state == st_ack);

	// operand selection, mirroring the decoder priority
	always_comb begin
		case (dec.sel)
			sel_syscall: sel_ops = '{op_a: v0, op_b: a0};
			sel_link:    sel_ops = '{op_a: issue.pc_plus_4, op_b: '0};
			sel_hi:      sel_ops = '{op_a: hi, op_b: '0};
			sel_lo:      sel_ops = '{op_a: lo, op_b: '0};
			default:     sel_ops = '{op_a: rd_a, op_b: rd_b};
		endcase
	end

	// captured on the commit edge from pre-write state and held
	// until the next accepted request
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			operands <= '0;
		end else if (commit) begin
			operands <= sel_ops;
		end
	end

endmodule

// ==== dv/operand_checker.sv ====
`timescale 1ns/1ps

module operand_checker
	import mips_isa_pkg::*;
	import regfile_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic req,
	input logic ack,
	input operands_t operands,
	input word_t v0,
	input word_t a0,
	input logic [127:0] test_name,
	input operands_t exp_ops,
	input word_t exp_v0,
	input word_t exp_a0,
	output int check_count,
	output int mismatch_count
);

	// ack as seen on the previous edge, so the first edge of an acknowledge stands out
	logic ack_q;
	// ack two edges back tells the one-cycle release apart from idle
	logic ack_qq;
	// req as sampled on the previous edge
	logic req_q;
	// ack level that the four-phase rules predict for the current edge
	logic exp_ack;
	int checks = 0;
	int mismatches = 0;

	assign check_count = checks;
	assign mismatch_count = mismatches;

	// a req seen in idle or while acknowledged gives ack on the next edge
	// a req seen during the release cycle has to wait one more edge
	assign exp_ack = req_q && (ack_q || !ack_qq);

	task automatic compare(input string field, input word_t expected, input word_t actual);
		checks++;
		if (expected !== actual) begin
			mismatches++;
			$display("CHECK FAILED %0s %0s: expected %h, actual %h",
				test_name, field, expected, actual);
		end
	endtask

	// sampling on the clock edge sees the values that settled during the previous cycle
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ack_q <= 1'b0;
			ack_qq <= 1'b0;
			req_q <= 1'b0;
		end else begin
			ack_q <= ack;
			ack_qq <= ack_q;
			req_q <= req;
			compare("ack", word_t'(exp_ack), word_t'(ack));
			if (ack && !ack_q) begin
				// the taps already show the writes of the commit edge here
				compare("op_a", exp_ops.op_a, operands.op_a);
				compare("op_b", exp_ops.op_b, operands.op_b);
				compare("v0", exp_v0, v0);
				compare("a0", exp_a0, a0);
			end else if (ack && req) begin
				// while req is held the registered pair must not move
				compare("held op_a", exp_ops.op_a, operands.op_a);
				compare("held op_b", exp_ops.op_b, operands.op_b);
			end
		end
	end

endmodule

// ==== dv/operand_fetch_tb.sv ====
`timescale 1ns/1ps

module operand_fetch_tb
	import mips_isa_pkg::*;
	import regfile_pkg::*;
;

	localparam int ack_timeout = 20;
	localparam wb_t no_wb = '0;
	localparam hilo_wr_t no_hilo = '0;
	localparam word_t stack_top = 32'h0000_fffc;

	// one row of the stimulus table
	// hold is the number of extra cycles that req stays up
	typedef struct packed {
		logic [127:0] name;
		issue_t issue;
		operands_t exp_ops;
		word_t exp_v0;
		word_t exp_a0;
		int hold;
	} entry_t;

	logic clk = 1'b0;
	logic arst_n;
	logic req;
	issue_t issue;
	logic ack;
	operands_t operands;
	word_t v0;
	word_t a0;

	// expected values of the entry in flight go to the checker
	logic [127:0] cur_name;
	operands_t exp_ops;
	word_t exp_v0;
	word_t exp_a0;

	entry_t tests [16];
	int n_tests = 0;
	int timeouts = 0;
	int checks;
	int mismatches;

	always #20 clk = ~clk;

	operand_fetch dut_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.req      (req),
		.issue    (issue),
		.ack      (ack),
		.operands (operands),
		.v0       (v0),
		.a0       (a0)
	);

	operand_checker checker_i (
		.clk            (clk),
		.arst_n         (arst_n),
		.req            (req),
		.ack            (ack),
		.operands       (operands),
		.v0             (v0),
		.a0             (a0),
		.test_name      (cur_name),
		.exp_ops        (exp_ops),
		.exp_v0         (exp_v0),
		.exp_a0         (exp_a0),
		.check_count    (checks),
		.mismatch_count (mismatches)
	);

	// R-type word with shamt zero
	function automatic word_t r_type(reg_idx_t rs, reg_idx_t rt, reg_idx_t rd, opfield_t funct);
		return {op_special, rs, rt, rd, 5'd0, funct};
	endfunction

	task automatic set_entry(input logic [127:0] name, input word_t instr, input word_t pc4,
		input wb_t wb, input hilo_wr_t hilo, input word_t op_a, input word_t op_b,
		input word_t v0_exp, input word_t a0_exp, input int hold);
		tests[n_tests] = '{name, '{instr, pc4, wb, hilo}, '{op_a, op_b}, v0_exp, a0_exp, hold};
		n_tests++;
	endtask

	// polls ack at each edge until it reaches level or the cycle budget runs out
	task automatic wait_ack(input logic level, input logic [127:0] name);
		int cycles;
		logic seen;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < ack_timeout) begin
			@(posedge clk);
			cycles++;
			seen = (ack == level);
		end
		if (!seen) begin
			timeouts++;
			$display("timeout in %0s: ack did not go to %0b within %0d cycles",
				name, level, ack_timeout);
		end
	endtask

	// expected values follow the register state left by every earlier row
	task automatic load_table();
		set_entry("reset_sp", r_type(reg_sp, reg_zero, 5'd10, 6'h20), 32'h0, no_wb, no_hilo,
			stack_top, 32'h0, 32'h0, 32'h0, 0);
		// $t0 is read by the same request that writes it, so the old zero comes back
		set_entry("wb_t0_old", r_type(5'd8, 5'd8, 5'd10, 6'h20), 32'h0,
			wb_t'{1'b1, 5'd8, 32'h1111_0001}, no_hilo, 32'h0, 32'h0, 32'h0, 32'h0, 0);
		set_entry("wb_t0_new", r_type(5'd8, reg_sp, 5'd10, 6'h20), 32'h0,
			wb_t'{1'b1, reg_zero, 32'hdead_beef}, no_hilo,
			32'h1111_0001, stack_top, 32'h0, 32'h0, 0);
		set_entry("zero_stays", r_type(reg_zero, 5'd8, 5'd10, 6'h20), 32'h0, no_wb, no_hilo,
			32'h0, 32'h1111_0001, 32'h0, 32'h0, 0);
		// link write beats the write-back aimed at $ra
		// the jump target ends in the syscall funct code, which only counts under op_special
		set_entry("jal_link", {op_jal, 26'h10c}, 32'h0040_0024,
			wb_t'{1'b1, reg_ra, 32'hbad0_0bad}, no_hilo, 32'h0040_0024, 32'h0, 32'h0, 32'h0, 0);
		// a plain read must not link, and its disabled write-back must leave $t0 alone
		set_entry("ra_read", r_type(reg_ra, reg_zero, 5'd10, 6'h20), 32'h0040_0028,
			wb_t'{1'b0, 5'd8, 32'hffff_ffff}, no_hilo,
			32'h0040_0024, 32'h0, 32'h0, 32'h0, 0);
		set_entry("mfhi_same_req", r_type(reg_zero, reg_zero, 5'd9, fn_mfhi), 32'h0, no_wb,
			hilo_wr_t'{1'b1, 32'haaaa_0001, 32'h5555_0002}, 32'h0, 32'h0, 32'h0, 32'h0, 0);
		set_entry("mfhi_after", r_type(reg_zero, reg_zero, 5'd9, fn_mfhi), 32'h0, no_wb,
			no_hilo, 32'haaaa_0001, 32'h0, 32'h0, 32'h0, 0);
		set_entry("mflo_after", r_type(reg_zero, reg_zero, 5'd9, fn_mflo), 32'h0, no_wb,
			no_hilo, 32'h5555_0002, 32'h0, 32'h0, 32'h0, 0);
		// $ra still holds the return address of the jal
		set_entry("write_v0", r_type(reg_ra, reg_zero, 5'd10, 6'h20), 32'h0,
			wb_t'{1'b1, reg_v0, 32'h0000_000a}, no_hilo,
			32'h0040_0024, 32'h0, 32'h0000_000a, 32'h0, 0);
		set_entry("write_a0", r_type(reg_v0, reg_a0, 5'd10, 6'h20), 32'h0,
			wb_t'{1'b1, reg_a0, 32'h1234_5678}, no_hilo,
			32'h0000_000a, 32'h0, 32'h0000_000a, 32'h1234_5678, 0);
		set_entry("syscall", r_type(reg_zero, reg_zero, reg_zero, fn_syscall), 32'h0, no_wb,
			no_hilo, 32'h0000_000a, 32'h1234_5678, 32'h0000_000a, 32'h1234_5678, 0);
		// $t1 holds zero and the write-back adds 0x10 while req stays up five more cycles
		set_entry("held_req", r_type(5'd9, 5'd8, 5'd10, 6'h20), 32'h0,
			wb_t'{1'b1, 5'd9, 32'h0000_0010}, no_hilo,
			32'h0, 32'h1111_0001, 32'h0000_000a, 32'h1234_5678, 5);
		set_entry("after_hold", r_type(5'd9, reg_sp, 5'd10, 6'h20), 32'h0, no_wb, no_hilo,
			32'h0000_0010, stack_top, 32'h0000_000a, 32'h1234_5678, 0);
	endtask

	initial begin
		arst_n = 1'b0;
		req = 1'b0;
		issue = '0;
		cur_name = '0;
		exp_ops = '0;
		exp_v0 = '0;
		exp_a0 = '0;
		load_table();
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;
		for (int i = 0; i < n_tests; i++) begin
			@(posedge clk);
			req <= 1'b1;
			issue <= tests[i].issue;
			cur_name <= tests[i].name;
			exp_ops <= tests[i].exp_ops;
			exp_v0 <= tests[i].exp_v0;
			exp_a0 <= tests[i].exp_a0;
			wait_ack(1'b1, tests[i].name);
			repeat (tests[i].hold) @(posedge clk);
			req <= 1'b0;
			wait_ack(1'b0, tests[i].name);
		end
		@(posedge clk);
		// the counters are settled once the checker has handled the last edge
		@(negedge clk);
		$display("checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// ==== tb.f ====
source/mips_isa_pkg.sv
source/regfile_pkg.sv
source/instr_decode.sv
source/reg_file.sv
source/hi_lo_regs.sv
source/operand_fetch.sv
dv/operand_checker.sv
dv/operand_fetch_tb.sv

// ==== Bender.yml ====
package:
  name: operand_fetch

sources:
  - files:
      - source/mips_isa_pkg.sv
      - source/regfile_pkg.sv
      - source/instr_decode.sv
      - source/reg_file.sv
      - source/hi_lo_regs.sv
      - source/operand_fetch.sv
  - target: test
    files:
      - dv/operand_checker.sv
      - dv/operand_fetch_tb.sv
